/* src/i2c_pkg.sv */
package i2c_pkg;

	// Clk cycles per quarter of an SCL period
	localparam int SCL_DIV = 25;
	localparam int DIV_W = $clog2(SCL_DIV);

	localparam int INIT_LEN = 4;
	localparam int INIT_IDX_W = $clog2(INIT_LEN);

	typedef struct packed {
		logic [7:0] hi;
		logic [7:0] lo;
	} addr_bytes_t;

	// register address, whole word or split by byte
	typedef union packed {
		logic [15:0] word;
		addr_bytes_t bytes;
	} reg_addr_u;

	typedef struct packed {
		logic       is_read;
		logic       wide_addr;
		reg_addr_u  addr;
		logic [7:0] wrdata;
	} reg_req_t;

	typedef struct packed {
		logic       start;
		logic       write;
		logic       read;
		logic       ack;
		logic       nack;
		logic       stop;
		logic [7:0] tx_data;
	} byte_cmd_t;

endpackage

/* src/i2c_init_sequencer.sv */
`timescale 1ns/100ps

module i2c_init_sequencer (
	input  logic              Clk,
	input  logic              Rst_n,
	input  logic              host_wr,
	input  logic              host_rd,
	input  logic              host_wide,
	input  logic [15:0]       host_addr,
	input  logic [7:0]        host_wrdata,
	output logic              busy,
	output i2c_pkg::reg_req_t req,
	output logic              req_valid,
	input  logic              rw_done,
	output logic              rd_valid
);
	import i2c_pkg::*;

	logic [INIT_IDX_W-1:0] init_idx;
	logic                  init_done;
	logic                  in_flight;
	logic                  rd_pend;
	logic                  host_go;
	logic                  issue;

	// power-up register writes, 8-bit addresses
	function automatic reg_req_t init_entry(input logic [INIT_IDX_W-1:0] idx);
		case (idx)
			2'd0: init_entry = {1'b0, 1'b0, 16'h0010, 8'hA5};
			2'd1: init_entry = {1'b0, 1'b0, 16'h0011, 8'h3C};
			2'd2: init_entry = {1'b0, 1'b0, 16'h0020, 8'h7E};
			default: init_entry = {1'b0, 1'b0, 16'h0021, 8'h01};
		endcase
	endfunction

	assign busy = !init_done || in_flight;
	assign host_go = !busy && (host_wr || host_rd);
	assign issue = !rw_done && !in_flight && (!init_done || host_go);
	assign rd_valid = rw_done && rd_pend;

	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			init_idx <= '0;
			init_done <= 1'b0;
			in_flight <= 1'b0;
			rd_pend <= 1'b0;
			req_valid <= 1'b0;
		end else begin
			req_valid <= 1'b0;
			if (rw_done) begin
				in_flight <= 1'b0;
				rd_pend <= 1'b0;
				if (!init_done) begin
					init_idx <= init_idx + 1'b1;
					init_done <= (init_idx == INIT_IDX_W'(INIT_LEN - 1));
				end
			end else if (issue) begin
				in_flight <= 1'b1;
				req_valid <= 1'b1;
				// a write strobe wins over a read strobe
				rd_pend <= init_done && !host_wr;
			end
		end
	end

	always_ff @(posedge Clk) begin
		if (issue) begin
			if (!init_done) begin
				req <= init_entry(init_idx);
			end else begin
				req.is_read <= !host_wr;
				req.wide_addr <= host_wide;
				req.addr.word <= host_addr;
				req.wrdata <= host_wrdata;
			end
		end
	end

endmodule

/* src/i2c_control.sv */
`timescale 1ns/100ps

module i2c_control (
	input  logic               Clk,
	input  logic               Rst_n,
	input  i2c_pkg::reg_req_t  req,
	input  logic               req_valid,
	input  logic [6:0]         device_id,
	input  logic [31:0]        dly_cnt_max,
	output i2c_pkg::byte_cmd_t cmd,
	output logic               go,
	input  logic               trans_done,
	input  logic               ack_o,
	input  logic [7:0]         rx_data,
	output logic [7:0]         rddata,
	output logic               nack_seen,
	output logic               rw_done
);
	import i2c_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		SEND,
		WAIT,
		DLY
	} state_t;

	state_t      state;
	reg_req_t    req_q;
	logic [6:0]  dev_q;
	logic [2:0]  cnt;
	logic [31:0] dly_cnt;

	// byte steps: 0 device, 1 addr hi, 2 addr lo, 3 data or re-address, 4 read
	always_comb begin
		cmd = '0;
		case (cnt)
			3'd0: begin
				cmd.start = 1'b1;
				cmd.write = 1'b1;
				cmd.tx_data = {dev_q, 1'b0};
			end
			3'd1: begin
				cmd.write = 1'b1;
				cmd.tx_data = req_q.addr.bytes.hi;
			end
			3'd2: begin
				cmd.write = 1'b1;
				cmd.tx_data = req_q.addr.bytes.lo;
			end
			3'd3: begin
				cmd.write = 1'b1;
				if (req_q.is_read) begin
					// repeated start with the read bit
					cmd.start = 1'b1;
					cmd.tx_data = {dev_q, 1'b1};
				end else begin
					cmd.stop = 1'b1;
					cmd.tx_data = req_q.wrdata;
				end
			end
			3'd4: begin
				cmd.read = 1'b1;
				cmd.nack = 1'b1;
				cmd.stop = 1'b1;
			end
			default: ;
		endcase
	end

	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			state <= IDLE;
			cnt <= '0;
			dly_cnt <= '0;
			go <= 1'b0;
			rw_done <= 1'b0;
			nack_seen <= 1'b0;
			rddata <= '0;
		end else begin
			go <= 1'b0;
			rw_done <= 1'b0;
			case (state)
				IDLE: begin
					if (req_valid) begin
						cnt <= '0;
						nack_seen <= 1'b0;
						state <= SEND;
					end
				end
				SEND: begin
					go <= 1'b1;
					state <= WAIT;
				end
				WAIT: begin
					if (trans_done) begin
						// only written bytes carry a slave acknowledge
						if (cnt != 3'd4)
							nack_seen <= nack_seen | ack_o;
						state <= SEND;
						case (cnt)
							3'd0: cnt <= req_q.wide_addr ? 3'd1 : 3'd2;
							3'd1: cnt <= 3'd2;
							3'd2: cnt <= 3'd3;
							3'd3: begin
								if (req_q.is_read)
									cnt <= 3'd4;
								else
									state <= DLY;
							end
							default: begin
								rddata <= rx_data;
								state <= DLY;
							end
						endcase
					end
				end
				DLY: begin
					if (dly_cnt >= dly_cnt_max) begin
						dly_cnt <= '0;
						rw_done <= 1'b1;
						state <= IDLE;
					end else begin
						dly_cnt <= dly_cnt + 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge Clk) begin
		if (state == IDLE && req_valid) begin
			req_q <= req;
			dev_q <= device_id;
		end
	end

endmodule

/* src/i2c_bit_shift.sv */
`timescale 1ns/100ps

module i2c_bit_shift (
	input  logic               Clk,
	input  logic               Rst_n,
	input  i2c_pkg::byte_cmd_t cmd,
	input  logic               go,
	output logic [7:0]         rx_data,
	output logic               trans_done,
	output logic               ack_o,
	output logic               scl,
	inout  wire                sda
);
	import i2c_pkg::*;

	typedef enum logic [2:0] {
		IDLE,
		START,
		BITS,
		ACKB,
		STOP
	} phase_t;

	phase_t           phase;
	logic [DIV_W-1:0] div_cnt;
	logic [1:0]       qtr;
	logic [2:0]       bit_cnt;
	logic [7:0]       shreg;
	logic             bus_held;
	logic             sda_low;
	logic             scl_nxt;
	logic             sda_low_nxt;
	logic             tick;

	// open drain, only ever pull low
	assign sda = sda_low ? 1'b0 : 1'bz;
	assign tick = (div_cnt == DIV_W'(SCL_DIV - 1));

	always_comb begin
		scl_nxt = 1'b1;
		sda_low_nxt = 1'b0;
		case (phase)
			// scl held low between bytes of one transfer
			IDLE: scl_nxt = !bus_held;
			START: begin
				scl_nxt = (qtr == 2'd1) || (qtr == 2'd2);
				sda_low_nxt = qtr[1];
			end
			BITS: begin
				scl_nxt = qtr[0] ^ qtr[1];
				sda_low_nxt = cmd.write && !shreg[7];
			end
			ACKB: begin
				scl_nxt = qtr[0] ^ qtr[1];
				sda_low_nxt = cmd.read && cmd.ack && !cmd.nack;
			end
			STOP: begin
				scl_nxt = (qtr != 2'd0);
				sda_low_nxt = !qtr[1];
			end
			default: ;
		endcase
	end

	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			phase <= IDLE;
			div_cnt <= '0;
			qtr <= '0;
			bit_cnt <= '0;
			bus_held <= 1'b0;
			trans_done <= 1'b0;
			ack_o <= 1'b0;
			scl <= 1'b1;
			sda_low <= 1'b0;
		end else begin
			trans_done <= 1'b0;
			scl <= scl_nxt;
			sda_low <= sda_low_nxt;
			if (phase == IDLE) begin
				div_cnt <= '0;
				qtr <= '0;
				bit_cnt <= '0;
				if (go)
					phase <= cmd.start ? START : BITS;
			end else if (!tick) begin
				div_cnt <= div_cnt + 1'b1;
			end else begin
				div_cnt <= '0;
				qtr <= qtr + 1'b1;
				// high midpoint of the ack clock, 1 means no ack
				if (phase == ACKB && qtr == 2'd1)
					ack_o <= cmd.write && sda;
				if (qtr == 2'd3) begin
					case (phase)
						START: phase <= BITS;
						BITS: begin
							bit_cnt <= bit_cnt + 1'b1;
							if (bit_cnt == 3'd7)
								phase <= ACKB;
						end
						ACKB: begin
							if (cmd.stop) begin
								phase <= STOP;
							end else begin
								phase <= IDLE;
								bus_held <= 1'b1;
								trans_done <= 1'b1;
							end
						end
						default: begin
							phase <= IDLE;
							bus_held <= 1'b0;
							trans_done <= 1'b1;
						end
					endcase
				end
			end
		end
	end

	// msb first, shared by transmit and receive
	always_ff @(posedge Clk) begin
		if (phase == IDLE && go) begin
			shreg <= cmd.tx_data;
		end else if (phase == BITS && tick) begin
			if (qtr == 2'd1 && cmd.read)
				shreg <= {shreg[6:0], sda};
			else if (qtr == 2'd3 && cmd.write)
				shreg <= {shreg[6:0], 1'b0};
		end
		if (phase == ACKB && tick && qtr == 2'd3)
			rx_data <= shreg;
	end

endmodule

/* src/i2c_reg_top.sv */
`timescale 1ns/100ps

module i2c_reg_top (
	input  logic        Clk,
	input  logic        Rst_n,
	input  logic        host_wr,
	input  logic        host_rd,
	input  logic        host_wide,
	input  logic [15:0] host_addr,
	input  logic [7:0]  host_wrdata,
	input  logic [6:0]  device_id,
	input  logic [31:0] dly_cnt_max,
	output logic        busy,
	output logic        rd_valid,
	output logic [7:0]  rddata,
	output logic        nack,
	output logic        scl,
	inout  wire         sda
);
	import i2c_pkg::*;

	reg_req_t   req;
	byte_cmd_t  cmd;
	logic       req_valid;
	logic       rw_done;
	logic       go;
	logic       trans_done;
	logic       ack_o;
	logic [7:0] rx_data;

	i2c_init_sequencer u_seq (
		.Clk         (Clk),
		.Rst_n       (Rst_n),
		.host_wr     (host_wr),
		.host_rd     (host_rd),
		.host_wide   (host_wide),
		.host_addr   (host_addr),
		.host_wrdata (host_wrdata),
		.busy        (busy),
		.req         (req),
		.req_valid   (req_valid),
		.rw_done     (rw_done),
		.rd_valid    (rd_valid)
	);

	i2c_control u_ctrl (
		.Clk         (Clk),
		.Rst_n       (Rst_n),
		.req         (req),
		.req_valid   (req_valid),
		.device_id   (device_id),
		.dly_cnt_max (dly_cnt_max),
		.cmd         (cmd),
		.go          (go),
		.trans_done  (trans_done),
		.ack_o       (ack_o),
		.rx_data     (rx_data),
		.rddata      (rddata),
		.nack_seen   (nack),
		.rw_done     (rw_done)
	);

	i2c_bit_shift u_shift (
		.Clk         (Clk),
		.Rst_n       (Rst_n),
		.cmd         (cmd),
		.go          (go),
		.rx_data     (rx_data),
		.trans_done  (trans_done),
		.ack_o       (ack_o),
		.scl         (scl),
		.sda         (sda)
	);

endmodule

/* test/i2c_slave_model.sv */
`timescale 1ns/100ps

module i2c_slave_model (
	input  logic [6:0] dev_addr,
	input  logic       addr_wide,
	input  logic       scl,
	inout  wire        sda
);
	logic [7:0] mem [0:255];
	logic       sda_low;
	logic       active;
	logic       rx;
	logic       to_tx;
	logic       master_nack;
	logic [7:0] shreg;
	logic [7:0] ptr;
	int         bit_cnt;
	int         byte_idx;
	logic       prev_scl;
	logic       prev_sda;

	assign sda = sda_low ? 1'b0 : 1'bz;

	initial begin
		for (int i = 0; i < 256; i++)
			mem[i] = 8'(i) ^ 8'h5A;
		sda_low = 1'b0;
		active = 1'b0;
		rx = 1'b1;
		to_tx = 1'b0;
		master_nack = 1'b0;
		shreg = '0;
		ptr = '0;
		bit_cnt = 0;
		byte_idx = 0;
		prev_scl = 1'b1;
		prev_sda = 1'b1;
	end

	// device byte, then address byte or bytes, then data
	task automatic take_byte(input logic [7:0] b);
		if (byte_idx == 0) begin
			if (b[7:1] == dev_addr) begin
				sda_low = 1'b1;
				to_tx = b[0];
			end else begin
				// not ours, wait for the next start
				active = 1'b0;
			end
		end else begin
			sda_low = 1'b1;
			if (byte_idx == (addr_wide ? 2 : 1)) begin
				ptr = b;
			end else if (byte_idx > (addr_wide ? 2 : 1)) begin
				mem[ptr] = b;
				ptr = ptr + 1'b1;
			end
		end
		byte_idx++;
	endtask

	always @(scl or sda) begin
		if (scl === 1'b1 && prev_scl === 1'b1 && sda !== prev_sda) begin
			if (sda === 1'b0) begin
				// start or repeated start
				active = 1'b1;
				rx = 1'b1;
				to_tx = 1'b0;
				bit_cnt = 0;
				byte_idx = 0;
				sda_low = 1'b0;
			end else if (sda === 1'b1) begin
				active = 1'b0;
				sda_low = 1'b0;
			end
		end else if (active && scl === 1'b1 && prev_scl === 1'b0) begin
			if (bit_cnt < 8) begin
				if (rx)
					shreg = {shreg[6:0], sda === 1'b1};
				bit_cnt++;
			end else begin
				master_nack = (sda === 1'b1);
				bit_cnt = 9;
			end
		end else if (active && scl === 1'b0 && prev_scl === 1'b1) begin
			if (bit_cnt == 8) begin
				if (rx)
					take_byte(shreg);
				else
					sda_low = 1'b0;
			end else if (bit_cnt == 9) begin
				sda_low = 1'b0;
				bit_cnt = 0;
				if (to_tx) begin
					rx = 1'b0;
					to_tx = 1'b0;
					master_nack = 1'b0;
				end
				if (!rx) begin
					if (master_nack) begin
						active = 1'b0;
					end else begin
						shreg = mem[ptr];
						ptr = ptr + 1'b1;
						sda_low = !shreg[7];
					end
				end
			end else if (bit_cnt != 0 && !rx) begin
				// next bit goes out while scl is low
				shreg = {shreg[6:0], 1'b0};
				sda_low = !shreg[7];
			end
		end
		prev_scl = scl;
		prev_sda = sda;
	end

endmodule

/* test/tb_i2c_reg_top.sv */
`timescale 1ns/100ps

module tb_i2c_reg_top;
	import i2c_pkg::*;

	localparam logic [6:0] SLAVE_ID = 7'h21;
	localparam int MAX_DLY = 200;
	// 40 accesses of five bytes each at the longest gap
	localparam int WATCHDOG_CYCLES = 40 * (5 * 40 * SCL_DIV + MAX_DLY);

	logic        Clk;
	logic        Rst_n;
	logic        host_wr;
	logic        host_rd;
	logic        host_wide;
	logic [15:0] host_addr;
	logic [7:0]  host_wrdata;
	logic [6:0]  device_id;
	logic [31:0] dly_cnt_max;
	logic        busy;
	logic        rd_valid;
	logic [7:0]  rddata;
	logic        nack;
	logic        scl;
	wire         sda;
	logic        slave_wide;

	logic [7:0]  init_addr [INIT_LEN] = '{8'h10, 8'h11, 8'h20, 8'h21};
	logic [7:0]  init_data [INIT_LEN] = '{8'hA5, 8'h3C, 8'h7E, 8'h01};
	logic [7:0]  model_mem [0:255];
	logic [7:0]  addr_list [4];
	logic [15:0] wide_list [3];
	logic [7:0]  exp_rddata;
	logic        exp_nack;
	logic [15:0] cur_addr;
	logic        busy_q;
	int          err_cnt;
	int          check_cnt;
	int          rd_seen;
	int          rd_mark;
	int          test_cnt;
	int          test_err_base;
	int          init_cycles;
	int          rnd_seed;

	pullup (sda);

	i2c_reg_top dut (
		.Clk         (Clk),
		.Rst_n       (Rst_n),
		.host_wr     (host_wr),
		.host_rd     (host_rd),
		.host_wide   (host_wide),
		.host_addr   (host_addr),
		.host_wrdata (host_wrdata),
		.device_id   (device_id),
		.dly_cnt_max (dly_cnt_max),
		.busy        (busy),
		.rd_valid    (rd_valid),
		.rddata      (rddata),
		.nack        (nack),
		.scl         (scl),
		.sda         (sda)
	);

	i2c_slave_model slave (
		.dev_addr  (SLAVE_ID),
		.addr_wide (slave_wide),
		.scl       (scl),
		.sda       (sda)
	);

	always #2 Clk = ~Clk;

	// slave stores at the low address byte only
	function automatic logic [7:0] ref_access(input logic is_rd, input logic [15:0] addr,
		input logic [7:0] data);
		if (!is_rd)
			model_mem[addr[7:0]] = data;
		return model_mem[addr[7:0]];
	endfunction

	task automatic issue_access(input logic is_rd, input logic wide, input logic [15:0] addr,
		input logic [7:0] data);
		@(negedge Clk);
		while (busy)
			@(negedge Clk);
		cur_addr = addr;
		exp_nack = (device_id != SLAVE_ID);
		if (!exp_nack)
			exp_rddata = ref_access(is_rd, addr, data);
		host_wr = !is_rd;
		host_rd = is_rd;
		host_wide = wide;
		host_addr = addr;
		host_wrdata = data;
		@(negedge Clk);
		host_wr = 1'b0;
		host_rd = 1'b0;
		check_cnt++;
		assert (busy) else begin
			$display("FAIL %0t: access to 0x%04h was not accepted", $time, addr);
			err_cnt++;
		end
	endtask

	task automatic wait_done(input logic is_rd);
		int rd_before;
		rd_before = rd_seen;
		while (busy)
			@(negedge Clk);
		if (is_rd) begin
			check_cnt++;
			assert (rd_seen == rd_before + 1) else begin
				$display("Read of 0x%04h finished without a rd_valid pulse", cur_addr);
				err_cnt++;
			end
		end
	endtask

	task automatic write_reg(input logic wide, input logic [15:0] addr, input logic [7:0] data);
		issue_access(1'b0, wide, addr, data);
		wait_done(1'b0);
	endtask

	task automatic read_reg(input logic wide, input logic [15:0] addr);
		issue_access(1'b1, wide, addr, 8'h00);
		wait_done(1'b1);
	endtask

	task automatic report_test(input string name);
		test_cnt++;
		$display("test %0d (%s) done, %0d errors", test_cnt, name, err_cnt - test_err_base);
		test_err_base = err_cnt;
	endtask

	task automatic expect_idle(input int cycles);
		repeat (cycles) begin
			@(negedge Clk);
			check_cnt++;
			assert (!busy) else begin
				$display("FAIL %0t: busy high with no access pending", $time);
				err_cnt++;
			end
			// both lines released after the stop
			check_cnt++;
			assert (scl === 1'b1 && sda === 1'b1) else begin
				$display("FAIL %0t: idle bus shows scl %b sda %b", $time, scl, sda);
				err_cnt++;
			end
		end
	endtask

	// read data at rd_valid, nack wherever busy falls
	always @(negedge Clk) begin
		if (!Rst_n) begin
			busy_q = 1'b1;
		end else begin
			if (rd_valid) begin
				rd_seen++;
				check_cnt++;
				assert (rddata == exp_rddata) else begin
					$display("FAIL %0t: read 0x%04h gave 0x%02h, expected 0x%02h",
						$time, cur_addr, rddata, exp_rddata);
					err_cnt++;
				end
			end
			if (busy_q && !busy) begin
				check_cnt++;
				assert (nack == exp_nack) else begin
					$display("FAIL %0t: nack is %b after access to 0x%04h, expected %b",
						$time, nack, cur_addr, exp_nack);
					err_cnt++;
				end
			end
			busy_q = busy;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES + 20) @(posedge Clk);
		$display("Timeout: the run did not end within %0d clock cycles", WATCHDOG_CYCLES);
		$display("Test FAILED");
		$finish;
	end

	initial begin
		rnd_seed = 32'hb0be_a84d;
		void'($urandom(rnd_seed));
		Clk = 1'b0;
		Rst_n = 1'b0;
		host_wr = 1'b0;
		host_rd = 1'b0;
		host_wide = 1'b0;
		host_addr = '0;
		host_wrdata = '0;
		device_id = SLAVE_ID;
		dly_cnt_max = 32'd4;
		slave_wide = 1'b0;
		exp_rddata = '0;
		exp_nack = 1'b0;
		cur_addr = '0;
		err_cnt = 0;
		check_cnt = 0;
		rd_seen = 0;
		test_cnt = 0;
		test_err_base = 0;
		// same power-up contents as the slave
		for (int i = 0; i < 256; i++)
			model_mem[i] = 8'(i) ^ 8'h5A;
		repeat (10) @(posedge Clk);
		@(negedge Clk);
		Rst_n = 1'b1;

		init_cycles = 0;
		while (busy) begin
			init_cycles++;
			@(negedge Clk);
		end
		check_cnt++;
		assert (init_cycles >= INIT_LEN * 3 * 32 * SCL_DIV) else begin
			$display("FAIL %0t: busy dropped after %0d cycles", $time, init_cycles);
			err_cnt++;
		end
		for (int i = 0; i < INIT_LEN; i++)
			void'(ref_access(1'b0, {8'h00, init_addr[i]}, init_data[i]));
		for (int i = 0; i < INIT_LEN; i++)
			read_reg(1'b0, {8'h00, init_addr[i]});
		report_test("init table");

		for (int i = 0; i < 4; i++) begin
			addr_list[i] = 8'($urandom);
			write_reg(1'b0, {8'h00, addr_list[i]}, 8'($urandom));
		end
		for (int i = 0; i < 4; i++)
			read_reg(1'b0, {8'h00, addr_list[i]});
		report_test("8-bit address");

		slave_wide = 1'b1;
		for (int i = 0; i < 3; i++) begin
			wide_list[i] = 16'($urandom);
			write_reg(1'b1, wide_list[i], 8'($urandom));
		end
		for (int i = 0; i < 3; i++)
			read_reg(1'b1, wide_list[i]);
		slave_wide = 1'b0;
		report_test("16-bit address");

		device_id = SLAVE_ID + 7'd1;
		write_reg(1'b0, 16'h0020, 8'h5C);
		device_id = SLAVE_ID;
		read_reg(1'b0, 16'h0020);
		report_test("wrong device id");

		// second strobe lands while the first write is in flight
		issue_access(1'b0, 1'b0, 16'h0030, 8'($urandom));
		host_wr = 1'b1;
		host_addr = 16'h0021;
		host_wrdata = ~model_mem[8'h21];
		@(negedge Clk);
		host_wr = 1'b0;
		wait_done(1'b0);
		expect_idle(20);
		check_cnt++;
		assert (slave.mem[8'h21] == model_mem[8'h21]) else begin
			$display("FAIL %0t: slave holds 0x%02h at 0x21, expected 0x%02h",
				$time, slave.mem[8'h21], model_mem[8'h21]);
			err_cnt++;
		end
		read_reg(1'b0, 16'h0021);
		report_test("strobe while busy");

		rd_mark = rd_seen;
		for (int i = 0; i < 3; i++) begin
			dly_cnt_max = $urandom_range(MAX_DLY);
			write_reg(1'b0, {8'h00, addr_list[i]}, 8'($urandom));
			expect_idle(3);
			dly_cnt_max = $urandom_range(MAX_DLY);
			read_reg(1'b0, {8'h00, addr_list[i]});
			expect_idle(3);
		end
		check_cnt++;
		assert (rd_seen == rd_mark + 3) else begin
			$display("Only %0d of 3 reads gave a rd_valid pulse", rd_seen - rd_mark);
			err_cnt++;
		end
		report_test("random gap");

		$display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

/* i2c_reg_access.f */
src/i2c_pkg.sv
src/i2c_init_sequencer.sv
src/i2c_control.sv
src/i2c_bit_shift.sv
src/i2c_reg_top.sv
test/i2c_slave_model.sv
test/tb_i2c_reg_top.sv

/* Bender.yml */
package:
  name: i2c_reg_access

sources:
  - src/i2c_pkg.sv
  - src/i2c_init_sequencer.sv
  - src/i2c_control.sv
  - src/i2c_bit_shift.sv
  - src/i2c_reg_top.sv
  - target: test
    files:
      - test/i2c_slave_model.sv
      - test/tb_i2c_reg_top.sv
